// File: hw/madd_arith_pkg.sv
`default_nettype none

package madd_arith_pkg;

	// headroom above the double-width product so that the sum of product and C
	// and the rounding increment can never wrap before the saturate stage
	localparam int guard_bits = 8;

	// operand width used when the top level is not overridden
	localparam int default_data_width = 16;

endpackage

`default_nettype wire

// File: hw/madd_ctrl_pkg.sv
`default_nettype none

package madd_ctrl_pkg;

	// right shift applied to the product in the range 0 to 31
	typedef logic [4:0] shift_amt_t;

	// destination tag that leaves together with the result
	typedef logic [3:0] dest_t;

	// control of one operation that travels stage to stage beside the data
	typedef struct packed {
		shift_amt_t shift;
		logic       shift_disable;
		logic       signedness;
		logic       saturate_disable;
		dest_t      dest;
	} madd_ctrl_t;

endpackage

`default_nettype wire

// File: hw/madd_stage_if.sv
`timescale 1ns/1ns
`default_nettype none

interface madd_stage_if #(
	parameter int data_width = madd_arith_pkg::default_data_width
);

	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits;

	logic valid;
	logic ready;

	madd_ctrl_pkg::madd_ctrl_t ctrl;

	// the running datapath value holds the product at first and the sum later on
	logic signed [full_width - 1 : 0] value;

	// the addend travels unchanged as far as the add stage
	logic signed [data_width - 1 : 0] arg_c;

	modport source (
		output valid,
		output ctrl,
		output value,
		output arg_c,
		input  ready
	);

	modport sink (
		input  valid,
		input  ctrl,
		input  value,
		input  arg_c,
		output ready
	);

endinterface

`default_nettype wire

// File: hw/madd_multiply_stage.sv
`timescale 1ns/1ns
`default_nettype none

module madd_multiply_stage #(
	parameter int data_width = madd_arith_pkg::default_data_width
) (
	input  wire clk,
	input  wire reset,
	input  wire in_valid,
	output logic in_ready,
	input  wire signed [data_width - 1 : 0] arg_a,
	input  wire signed [data_width - 1 : 0] arg_b,
	input  wire signed [data_width - 1 : 0] arg_c,
	input  wire madd_ctrl_pkg::madd_ctrl_t ctrl,
	madd_stage_if.source out
);

	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits;

	logic take_in;
	logic take_out;
	logic signed [full_width - 1 : 0] a_ext;
	logic signed [full_width - 1 : 0] b_ext;

	assign in_ready = ~out.valid | out.ready;
	assign take_in = in_valid & in_ready;
	assign take_out = out.valid & out.ready;

	// operands are widened first so the low full_width bits of the product are exact
	assign a_ext = ctrl.signedness ? full_width'(arg_a) : full_width'($unsigned(arg_a));
	assign b_ext = ctrl.signedness ? full_width'(arg_b) : full_width'($unsigned(arg_b));

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (take_in) begin
			out.valid <= 1'b1;
		end else if (take_out) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			out.value <= a_ext * b_ext;
			out.ctrl <= ctrl;
			out.arg_c <= arg_c;
		end
	end

	// a stalled output must not change under the next stage
	assert property (@(posedge clk) disable iff (reset)
		out.valid && !out.ready |=> out.valid && $stable(out.value) && $stable(out.ctrl));

endmodule

`default_nettype wire

// File: hw/madd_shift_coarse.sv
`timescale 1ns/1ns
`default_nettype none

module madd_shift_coarse #(
	parameter int data_width = madd_arith_pkg::default_data_width
) (
	input  wire clk,
	input  wire reset,
	madd_stage_if.sink in,
	madd_stage_if.source out,
	output logic round_bit
);

	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits;

	logic take_in;
	logic take_out;
	madd_ctrl_pkg::shift_amt_t shift;
	madd_ctrl_pkg::shift_amt_t cut_index;
	logic large_shift;
	logic signed [full_width - 1 : 0] sh8;
	logic signed [full_width - 1 : 0] sh12;
	logic [full_width - 1 : 0] below_cut;
	logic round_next;
	logic signed [full_width - 1 : 0] value_next;

	assign in.ready = ~out.valid | out.ready;
	assign take_in = in.valid & in.ready;
	assign take_out = out.valid & out.ready;

	assign shift = in.ctrl.shift;
	assign large_shift = 32'(shift) >= data_width;

	assign sh8 = shift[3] ? (in.value >>> 8) : in.value;
	assign sh12 = shift[2] ? (sh8 >>> 4) : sh8;

	// the bit just below the final cut decides rounding, so it is taken from the
	// unshifted product before the fine stage finishes the shift
	assign cut_index = shift - 5'd1;
	assign below_cut = in.value >> cut_index;
	assign round_next = below_cut[0] & (shift != '0) & ~in.ctrl.shift_disable & ~large_shift;

	always_comb begin
		if (in.ctrl.shift_disable) begin
			value_next = in.value;
		end else if (large_shift) begin
			value_next = '0;
		end else begin
			value_next = sh12;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (take_in) begin
			out.valid <= 1'b1;
		end else if (take_out) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			out.value <= value_next;
			round_bit <= round_next;
			out.ctrl <= in.ctrl;
			out.arg_c <= in.arg_c;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		out.valid && out.ctrl.shift_disable |-> !round_bit);

endmodule

`default_nettype wire

// File: hw/madd_shift_fine.sv
`timescale 1ns/1ns
`default_nettype none

module madd_shift_fine #(
	parameter int data_width = madd_arith_pkg::default_data_width
) (
	input  wire clk,
	input  wire reset,
	madd_stage_if.sink in,
	input  wire round_bit,
	madd_stage_if.source out
);

	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits;

	logic take_in;
	logic take_out;
	madd_ctrl_pkg::shift_amt_t shift;
	logic signed [full_width - 1 : 0] sh2;
	logic signed [full_width - 1 : 0] sh3;
	logic signed [full_width - 1 : 0] value_next;

	assign in.ready = ~out.valid | out.ready;
	assign take_in = in.valid & in.ready;
	assign take_out = out.valid & out.ready;

	assign shift = in.ctrl.shift;

	assign sh2 = shift[1] ? (in.value >>> 2) : in.value;
	assign sh3 = shift[0] ? (sh2 >>> 1) : sh2;

	// round half up by adding the bit captured below the cut
	assign value_next = in.ctrl.shift_disable ? in.value
		: sh3 + {{(full_width - 1){1'b0}}, round_bit};

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (take_in) begin
			out.valid <= 1'b1;
		end else if (take_out) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			out.value <= value_next;
			out.ctrl <= in.ctrl;
			out.arg_c <= in.arg_c;
		end
	end

endmodule

`default_nettype wire

// File: hw/madd_add_stage.sv
`timescale 1ns/1ns
`default_nettype none

module madd_add_stage #(
	parameter int data_width = madd_arith_pkg::default_data_width
) (
	input  wire clk,
	input  wire reset,
	madd_stage_if.sink in,
	madd_stage_if.source out
);

	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits;

	logic take_in;
	logic take_out;
	logic signed [full_width - 1 : 0] c_ext;

	assign in.ready = ~out.valid | out.ready;
	assign take_in = in.valid & in.ready;
	assign take_out = out.valid & out.ready;

	// C is widened over the whole datapath and keeps its sign only in signed mode
	assign c_ext = in.ctrl.signedness ? full_width'(in.arg_c)
		: full_width'($unsigned(in.arg_c));

	always_ff @(posedge clk) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (take_in) begin
			out.valid <= 1'b1;
		end else if (take_out) begin
			out.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			out.value <= in.value + c_ext;
			out.ctrl <= in.ctrl;
		end
	end

endmodule

`default_nettype wire

// File: hw/madd_saturate_stage.sv
`timescale 1ns/1ns
`default_nettype none

module madd_saturate_stage #(
	parameter int data_width = madd_arith_pkg::default_data_width,
	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits
) (
	input  wire clk,
	input  wire reset,
	madd_stage_if.sink in,
	output logic out_valid,
	input  wire out_ready,
	output logic signed [full_width - 1 : 0] result,
	output madd_ctrl_pkg::dest_t dest_out
);

	// limits of a signed word of twice the operand width
	localparam logic signed [full_width - 1 : 0] sat_max =
		(full_width'(1) <<< (2 * data_width - 1)) - full_width'(1);
	localparam logic signed [full_width - 1 : 0] sat_min = ~sat_max;

	logic take_in;
	logic take_out;
	logic signed [full_width - 1 : 0] clipped;

	assign in.ready = ~out_valid | out_ready;
	assign take_in = in.valid & in.ready;
	assign take_out = out_valid & out_ready;

	always_comb begin
		if (in.ctrl.saturate_disable) begin
			clipped = in.value;
		end else if (in.value > sat_max) begin
			clipped = sat_max;
		end else if (in.value < sat_min) begin
			clipped = sat_min;
		end else begin
			clipped = in.value;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (take_in) begin
			out_valid <= 1'b1;
		end else if (take_out) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take_in) begin
			result <= clipped;
			dest_out <= in.ctrl.dest;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		take_in && !in.ctrl.saturate_disable |=> out_valid && result >= sat_min && result <= sat_max);

endmodule

`default_nettype wire

// File: hw/madd_top.sv
`timescale 1ns/1ns
`default_nettype none

module madd_top #(
	parameter int data_width = madd_arith_pkg::default_data_width,
	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits
) (
	input  wire clk,
	input  wire reset,
	input  wire in_valid,
	output wire in_ready,
	input  wire signed [data_width - 1 : 0] arg_a,
	input  wire signed [data_width - 1 : 0] arg_b,
	input  wire signed [data_width - 1 : 0] arg_c,
	input  wire madd_ctrl_pkg::shift_amt_t shift,
	input  wire shift_disable,
	input  wire signedness,
	input  wire saturate_disable,
	input  wire madd_ctrl_pkg::dest_t dest_in,
	output wire out_valid,
	input  wire out_ready,
	output wire signed [full_width - 1 : 0] result,
	output wire madd_ctrl_pkg::dest_t dest_out
);

	madd_ctrl_pkg::madd_ctrl_t in_ctrl;
	wire round_bit;

	assign in_ctrl.shift = shift;
	assign in_ctrl.shift_disable = shift_disable;
	assign in_ctrl.signedness = signedness;
	assign in_ctrl.saturate_disable = saturate_disable;
	assign in_ctrl.dest = dest_in;

	madd_stage_if #(.data_width(data_width)) mul_to_coarse ();
	madd_stage_if #(.data_width(data_width)) coarse_to_fine ();
	madd_stage_if #(.data_width(data_width)) fine_to_add ();
	madd_stage_if #(.data_width(data_width)) add_to_sat ();

	madd_multiply_stage #(.data_width(data_width)) multiply (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.ctrl(in_ctrl),
		.out(mul_to_coarse.source)
	);

	madd_shift_coarse #(.data_width(data_width)) shift_coarse (
		.clk(clk),
		.reset(reset),
		.in(mul_to_coarse.sink),
		.out(coarse_to_fine.source),
		.round_bit(round_bit)
	);

	madd_shift_fine #(.data_width(data_width)) shift_fine (
		.clk(clk),
		.reset(reset),
		.in(coarse_to_fine.sink),
		.round_bit(round_bit),
		.out(fine_to_add.source)
	);

	madd_add_stage #(.data_width(data_width)) add (
		.clk(clk),
		.reset(reset),
		.in(fine_to_add.sink),
		.out(add_to_sat.source)
	);

	madd_saturate_stage #(.data_width(data_width)) saturate (
		.clk(clk),
		.reset(reset),
		.in(add_to_sat.sink),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.dest_out(dest_out)
	);

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns = 10,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// reset covers whole rising edges and drops just after the last one
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: tests/tb_madd.sv
`timescale 1ns/1ns
`default_nettype none

module tb_madd;

	localparam int data_width = madd_arith_pkg::default_data_width;
	localparam int full_width = 2 * data_width + madd_arith_pkg::guard_bits;
	localparam int table_rows = 15;
	localparam int random_ops = 200;
	localparam int timeout_cycles = (table_rows + random_ops) * 8 + 100;

	typedef struct packed {
		logic [data_width - 1 : 0] a;
		logic [data_width - 1 : 0] b;
		logic [data_width - 1 : 0] c;
		madd_ctrl_pkg::shift_amt_t shift;
		logic shift_disable;
		logic signedness;
		logic saturate_disable;
		madd_ctrl_pkg::dest_t dest;
	} op_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic signed [data_width - 1 : 0] arg_a;
	logic signed [data_width - 1 : 0] arg_b;
	logic signed [data_width - 1 : 0] arg_c;
	madd_ctrl_pkg::shift_amt_t shift;
	logic shift_disable;
	logic signedness;
	logic saturate_disable;
	madd_ctrl_pkg::dest_t dest_in;
	logic out_valid;
	logic out_ready;
	logic signed [full_width - 1 : 0] result;
	madd_ctrl_pkg::dest_t dest_out;

	string row_name [table_rows];
	op_t row_op [table_rows];
	longint row_result [table_rows];
	int row_count = 0;
	op_t random_op [random_ops];
	int random_idle [random_ops];

	// operations in flight with the oldest at the front
	string pending_name [$];
	longint pending_result [$];
	madd_ctrl_pkg::dest_t pending_dest [$];

	logic [31:0] lfsr_state = 32'h7aad_11c6;
	logic random_phase = 1'b0;
	int error_count = 0;
	int test_count = 0;
	int failed_count = 0;
	int cycle_count = 0;

	tb_clock_gen #(.period_ns(10), .reset_cycles(10)) clock_gen (
		.clk(clk),
		.reset(reset)
	);

	madd_top #(.data_width(data_width)) dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.arg_a(arg_a),
		.arg_b(arg_b),
		.arg_c(arg_c),
		.shift(shift),
		.shift_disable(shift_disable),
		.signedness(signedness),
		.saturate_disable(saturate_disable),
		.dest_in(dest_in),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result),
		.dest_out(dest_out)
	);

	// taps 32, 22, 2, 1
	function automatic logic next_bit();
		logic feedback;
		feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], feedback};
		return feedback;
	endfunction

	function automatic logic [31:0] rand_bits(int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], next_bit()};
		end
		return bits;
	endfunction

	function automatic longint reference_result(op_t op);
		longint product;
		longint addend;
		longint value;
		longint limit;
		if (op.signedness) begin
			product = longint'($signed(op.a)) * longint'($signed(op.b));
			addend = longint'($signed(op.c));
		end else begin
			product = longint'(op.a) * longint'(op.b);
			addend = longint'(op.c);
		end
		if (op.shift_disable || op.shift == 0) begin
			value = product;
		end else if (int'(op.shift) >= data_width) begin
			value = 0;
		end else begin
			// round half up by adding half the weight of the dropped bits before the floor
			value = (product + (longint'(1) <<< (op.shift - 1))) >>> op.shift;
		end
		value = value + addend;
		limit = longint'(1) <<< (2 * data_width - 1);
		if (!op.saturate_disable && value > limit - 1) begin
			value = limit - 1;
		end
		if (!op.saturate_disable && value < -limit) begin
			value = -limit;
		end
		return value;
	endfunction

	task automatic check_value(string name, logic signed [63:0] expected,
		logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(string name, int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: failed", name);
			failed_count++;
		end
	endtask

	task automatic add_row(string name, int a, int b, int c, int sh, bit sd, bit sg,
		bit satd, longint expected);
		op_t op;
		op.a = data_width'(a);
		op.b = data_width'(b);
		op.c = data_width'(c);
		op.shift = madd_ctrl_pkg::shift_amt_t'(sh);
		op.shift_disable = sd;
		op.signedness = sg;
		op.saturate_disable = satd;
		op.dest = madd_ctrl_pkg::dest_t'(row_count);
		row_name[row_count] = name;
		row_op[row_count] = op;
		row_result[row_count] = expected;
		row_count++;
	endtask

	task automatic build_random_ops();
		op_t op;
		for (int i = 0; i < random_ops; i++) begin
			op.a = data_width'(rand_bits(data_width));
			op.b = data_width'(rand_bits(data_width));
			op.c = data_width'(rand_bits(data_width));
			op.shift = madd_ctrl_pkg::shift_amt_t'(rand_bits(5));
			op.shift_disable = rand_bits(3) == 0;
			op.signedness = rand_bits(1) != 0;
			op.saturate_disable = rand_bits(1) != 0;
			op.dest = madd_ctrl_pkg::dest_t'(rand_bits(4));
			random_op[i] = op;
			random_idle[i] = (rand_bits(2) == 0) ? int'(rand_bits(2)) : 0;
		end
	endtask

	// starts just after a rising edge and returns just after the edge that took the operation
	task automatic send_op(string name, op_t op, longint expected);
		in_valid = 1'b1;
		arg_a = op.a;
		arg_b = op.b;
		arg_c = op.c;
		shift = op.shift;
		shift_disable = op.shift_disable;
		signedness = op.signedness;
		saturate_disable = op.saturate_disable;
		dest_in = op.dest;
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		pending_name.push_back(name);
		pending_result.push_back(expected);
		pending_dest.push_back(op.dest);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic retire_output();
		int errors_before;
		string name;
		errors_before = error_count;
		if (pending_name.size() == 0) begin
			$display("a result left the pipeline with no operation pending, dest %0d", dest_out);
			error_count++;
		end else begin
			name = pending_name.pop_front();
			check_value(name, pending_result.pop_front(), 64'(result));
			check_value(name, 64'(pending_dest.pop_front()), 64'(dest_out));
			report_test(name, errors_before);
		end
	endtask

	// inputs and outputs are settled at the falling edge, and a transfer seen here
	// happens on the next rising edge
	always @(negedge clk) begin
		if (!reset && out_valid && out_ready) begin
			retire_output();
		end
	end

	initial begin
		out_ready = 1'b1;
		forever begin
			@(posedge clk);
			#1;
			out_ready = random_phase ? next_bit() : 1'b1;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout after %0d cycles with %0d operations still pending",
				cycle_count, pending_name.size());
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		in_valid = 1'b0;
		arg_a = '0;
		arg_b = '0;
		arg_c = '0;
		shift = '0;
		shift_disable = 1'b0;
		signedness = 1'b0;
		saturate_disable = 1'b0;
		dest_in = '0;

		add_row("signed_shift0", 3, -4, 5, 0, 0, 1, 0, -7);
		add_row("signed_round_up", 7, 3, 0, 1, 0, 1, 0, 11);
		add_row("signed_neg_round", -7, 3, 0, 1, 0, 1, 0, -10);
		add_row("signed_neg_half", -2, 3, 0, 2, 0, 1, 0, -1);
		add_row("signed_shift7", 1000, -300, 100, 7, 0, 1, 0, -2244);
		add_row("signed_shift15", -32768, -32768, -1, 15, 0, 1, 0, 32767);
		add_row("signed_neg_shift15", -12345, 6789, 0, 15, 0, 1, 0, -2558);
		add_row("unsigned_operands", 'hffff, 2, 'h8000, 0, 0, 0, 0, 163838);
		add_row("unsigned_shift4", 'h8000, 'h8000, 'hffff, 4, 0, 0, 0, 67174399);
		add_row("saturate_high", 'hffff, 'hffff, 'hffff, 0, 0, 0, 0, 2147483647);
		add_row("saturate_off", 'hffff, 'hffff, 'hffff, 0, 0, 0, 1, 64'd4294901760);
		add_row("shift_disable_signed", -100, 50, 7, 3, 1, 1, 0, -4993);
		add_row("shift_disable_unsigned", 'h8001, 3, 'hffff, 5, 1, 0, 0, 163842);
		add_row("large_shift16", 1234, 567, -42, 16, 0, 1, 0, -42);
		add_row("large_shift31", 'hffff, 'hffff, 'habcd, 31, 0, 0, 0, 43981);
		build_random_ops();

		@(negedge reset);
		@(negedge clk);
		check_value("after_reset_out_valid", 0, 64'(out_valid));
		check_value("after_reset_in_ready", 1, 64'(in_ready));
		report_test("after_reset", 0);
		@(posedge clk);
		#1;

		for (int i = 0; i < table_rows; i++) begin
			send_op(row_name[i], row_op[i], row_result[i]);
		end

		@(negedge clk);
		random_phase = 1'b1;
		@(posedge clk);
		#1;
		for (int i = 0; i < random_ops; i++) begin
			repeat (random_idle[i]) begin
				@(posedge clk);
				#1;
			end
			send_op($sformatf("random_%0d", i), random_op[i], reference_result(random_op[i]));
		end

		while (pending_name.size() != 0) begin
			@(negedge clk);
		end
		// any further output here would be a duplicate
		repeat (10) @(negedge clk);

		$display("tests %0d, failed %0d, errors %0d", test_count, failed_count, error_count);
		if (error_count == 0 && failed_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
hw/madd_arith_pkg.sv
hw/madd_ctrl_pkg.sv
hw/madd_stage_if.sv
hw/madd_multiply_stage.sv
hw/madd_shift_coarse.sv
hw/madd_shift_fine.sv
hw/madd_add_stage.sv
hw/madd_saturate_stage.sv
hw/madd_top.sv
tests/tb_clock_gen.sv
tests/tb_madd.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_madd -o sim_madd

output=$(./obj_dir/sim_madd)
echo "$output"
echo "$output" | grep -q '^TEST PASS$'
